/* all.f */
+incdir+include
hdl/fe_pkg.sv
hdl/instr_loader.sv
hdl/instr_decoder.sv
hdl/pair_issuer.sv
hdl/instr_frontend.sv
tb/fe_clock_gen.sv
tb/fe_assert.sv
tb/tb_instr_frontend.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the front end testbench with Verilator and runs it.
# Exits with a non-zero status unless the run prints the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps \
  -f all.f --top-module tb_instr_frontend -Mdir obj_dir -o sim_fe
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/sim_fe 2>&1)
sim_status=$?
echo "$sim_out"

if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -q "^Simulation PASSED$"; then
  exit 0
else
  echo "pass line not found in simulation output"
  exit 1
fi

/* tb/tb_instr_frontend.sv */
// Directed tests. Memory answers only loaded words, so fetch waits between tests.
`include "fe_defs.svh"

module tb_instr_frontend import fe_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int free_w        = $clog2(`FE_MAX_FREE + 1);
  localparam int total_instrs  = 24;
  localparam int hold_cycles   = 30;
  localparam int max_mem_delay = 3;
  localparam int stall_budget  = 4;
  localparam int timeout_cycles = 8 + hold_cycles + 40 +
                                  total_instrs * (max_mem_delay + stall_budget);

  typedef struct packed {
    logic [31:0] pc;
    fe_op_e      op;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [31:0] imm;
  } exp_t;

  logic clk, reset;
  logic imem_req, imem_valid, wb_valid;
  logic [`FE_XLEN-1:0] imem_addr;
  logic [31:0] imem_rdata_0, imem_rdata_1;
  logic [free_w-1:0] free_slots, free_prev;
  logic [4:0] wb_rd;
  logic issue_valid_0, issue_valid_1;
  logic [`FE_XLEN-1:0] issue_pc_0, issue_pc_1, issue_imm_0, issue_imm_1;
  fe_op_e issue_op_0, issue_op_1;
  logic [4:0] issue_rd_0, issue_rs1_0, issue_rs2_0;
  logic [4:0] issue_rd_1, issue_rs1_1, issue_rs2_1;

  logic [31:0] mem [0:255];
  logic [31:0] next_fetch_addr;
  exp_t        exp_q [$];
  int          prog_len, issued, cycle_count;

  fe_clock_gen clock_i (.clk(clk), .reset(reset));
  instr_frontend dut_i (.*);

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Simulation FAILED");
    $fatal(1, "run stopped on first failure");
  endtask

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("[ERROR] t=%0t %s: expected 0x%08h, got 0x%08h", $time, name, exp, act);
      fail_run({"value mismatch on ", name});
    end
  endtask

  // ##########################################################################
  // program building and the reference decode from the RV32I field layout

  task automatic emit(input fe_op_e op, input logic [4:0] rd, input logic [4:0] rs1,
                      input logic [4:0] rs2, input logic [31:0] imm);
    exp_t        e;
    logic [31:0] word;
    e = '0;
    e.op = op;
    e.pc = `FE_RESET_PC + 32'(prog_len * 4);
    case (op)
      op_alu: begin
        word = {7'b0, rs2, rs1, 3'b000, rd, 7'b0110011};
        {e.rd, e.rs1, e.rs2} = {rd, rs1, rs2};
      end
      op_alu_imm, op_load: begin
        word = {imm[11:0], rs1, (op == op_load) ? 3'b010 : 3'b000, rd,
                (op == op_load) ? 7'b0000011 : 7'b0010011};
        {e.rd, e.rs1} = {rd, rs1};
        e.imm = {{20{imm[11]}}, imm[11:0]};
      end
      op_store: begin
        word = {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
        {e.rs1, e.rs2} = {rs1, rs2};
        e.imm = {{20{imm[11]}}, imm[11:0]};
      end
      op_lui: begin
        word = {imm[31:12], rd, 7'b0110111};
        e.rd = rd;
        e.imm = {imm[31:12], 12'b0};
      end
      default: begin
        word = {imm[24:0], 7'h7f};            // unknown opcode with no registers or immediate.
      end
    endcase
    mem[prog_len] = word;
    prog_len++;
    exp_q.push_back(e);
  endtask

  // ##########################################################################
  // memory model and issue monitor

  task automatic serve_request();
    int idx;
    int delay;
    compare("imem_addr", next_fetch_addr, imem_addr);
    next_fetch_addr = next_fetch_addr + 32'd8;
    idx = int'((imem_addr - `FE_RESET_PC) >> 2);
    delay = 1 + int'($urandom % 3);
    while (idx + 1 >= prog_len) @(posedge clk);  // not loaded yet.
    repeat (delay) @(posedge clk);
    #2;
    imem_valid   = 1'b1;
    imem_rdata_0 = mem[idx];
    imem_rdata_1 = mem[idx + 1];
    @(posedge clk);
    #2;
    imem_valid = 1'b0;
  endtask

  always @(negedge clk) begin
    if (!reset && imem_req) begin
      serve_request();
    end
  end

  task automatic check_issue(input string s, input logic [31:0] pc, input fe_op_e op,
                             input logic [4:0] rd, input logic [4:0] rs1,
                             input logic [4:0] rs2, input logic [31:0] imm);
    exp_t e;
    if (exp_q.size() == 0) begin
      fail_run({"slot ", s, " issued an instruction beyond the loaded program"});
    end else begin
      e = exp_q.pop_front();
      compare({"issue_pc_", s}, e.pc, pc);
      compare({"issue_op_", s}, 32'(e.op), 32'(op));
      compare({"issue_rd_", s}, 32'(e.rd), 32'(rd));
      compare({"issue_rs1_", s}, 32'(e.rs1), 32'(rs1));
      compare({"issue_rs2_", s}, 32'(e.rs2), 32'(rs2));
      compare({"issue_imm_", s}, e.imm, imm);
      issued++;
    end
  endtask

  // slot 0 is popped first, so a slot 1 ahead of its slot 0 shows as a pc mismatch.
  always @(negedge clk) begin
    if (!reset) begin
      if (issue_valid_0) begin
        check_issue("0", issue_pc_0, issue_op_0, issue_rd_0, issue_rs1_0, issue_rs2_0,
                    issue_imm_0);
      end
      if (issue_valid_1) begin
        check_issue("1", issue_pc_1, issue_op_1, issue_rd_1, issue_rs1_1, issue_rs2_1,
                    issue_imm_1);
      end
      compare("issues within free_slots",
              32'((int'(issue_valid_0) + int'(issue_valid_1)) <= int'(free_prev)), 32'd1);
    end
    free_prev = free_slots;
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > timeout_cycles) begin
      fail_run("timeout, expected issues did not arrive in time");
    end
  end

  // ##########################################################################
  // stimulus helpers and tests

  task automatic wait_issued(input int target);
    while (issued < target) @(posedge clk);
  endtask

  task automatic hold_and_expect(input int cycles, input int count);
    repeat (cycles) @(posedge clk);
    compare("issued instruction count", 32'(count), 32'(issued));
  endtask

  task automatic drive_wb(input logic [4:0] r);
    @(posedge clk);
    #2;
    wb_valid = 1'b1;
    wb_rd    = r;
    @(posedge clk);
    #2;
    wb_valid = 1'b0;
  endtask

  task automatic set_free(input int n);
    @(posedge clk);
    #2;
    free_slots = free_w'(n);
  endtask

  task automatic reset_and_fetch_order();
    wait (reset == 1'b0);
    compare("imem_req", 32'd0, 32'(imem_req));
    compare("issue_valid_0", 32'd0, 32'(issue_valid_0));
    compare("issue_valid_1", 32'd0, 32'(issue_valid_1));
    while (!imem_req) @(negedge clk);
    compare("imem_addr", `FE_RESET_PC, imem_addr);  // later steps checked per request.
  endtask

  task automatic independent_pairs();
    int base;
    base = issued;
    emit(op_alu,     5'd10, 5'd1, 5'd2, 32'd0);
    emit(op_alu_imm, 5'd11, 5'd3, 5'd0, 32'hffff_fffb);
    emit(op_load,    5'd12, 5'd4, 5'd0, 32'd2047);
    emit(op_store,   5'd0,  5'd1, 5'd2, 32'hffff_f800);
    emit(op_lui,     5'd13, 5'd0, 5'd0, 32'habcd_e000);
    emit(op_illegal, 5'd0,  5'd0, 5'd0, 32'h0123_4567);
    emit(op_alu_imm, 5'd0,  5'd1, 5'd0, 32'd5);      // x0 write leaves x0 free.
    emit(op_alu,     5'd14, 5'd0, 5'd0, 32'd0);
    emit(op_load,    5'd15, 5'd2, 5'd0, 32'hffff_ffff);
    emit(op_store,   5'd0,  5'd3, 5'd4, 32'h0000_02a5);
    emit(op_lui,     5'd16, 5'd0, 5'd0, 32'hffff_f000);
    emit(op_alu,     5'd17, 5'd3, 5'd4, 32'd0);
    wait_issued(base + 12);
  endtask

  task automatic pair_dependence();
    int base;
    base = issued;
    emit(op_alu_imm, 5'd20, 5'd1,  5'd0, 32'd3);
    emit(op_alu,     5'd21, 5'd20, 5'd2, 32'd0);
    wait_issued(base + 1);
    hold_and_expect(6, base + 1);
    drive_wb(5'd20);
    wait_issued(base + 2);
  endtask

  task automatic scoreboard_wait();
    int base;
    base = issued;
    emit(op_lui,     5'd22, 5'd0,  5'd0, 32'h1234_5000);
    emit(op_illegal, 5'd0,  5'd0,  5'd0, 32'h0abc_def0);
    emit(op_load,    5'd24, 5'd22, 5'd0, 32'hffff_fff8);
    emit(op_store,   5'd0,  5'd3,  5'd4, 32'd100);
    wait_issued(base + 2);
    hold_and_expect(8, base + 2);
    drive_wb(5'd0);
    hold_and_expect(6, base + 2);
    drive_wb(5'd22);
    wait_issued(base + 4);
  endtask

  task automatic back_pressure();
    int base;
    base = issued;
    set_free(0);
    emit(op_alu_imm, 5'd26, 5'd1, 5'd0, 32'd1);
    emit(op_alu,     5'd27, 5'd2, 5'd3, 32'd0);
    emit(op_load,    5'd28, 5'd4, 5'd0, 32'd16);
    emit(op_store,   5'd0,  5'd1, 5'd2, 32'hffff_fffc);
    emit(op_lui,     5'd29, 5'd0, 5'd0, 32'h0000_1000);
    emit(op_alu_imm, 5'd30, 5'd0, 5'd0, 32'hffff_ffff);
    hold_and_expect(10, base);
    set_free(1);
    wait_issued(base + 6);
    set_free(`FE_MAX_FREE);
  endtask

  initial begin
    void'($urandom(71994));
    imem_valid      = 1'b0;
    imem_rdata_0    = '0;
    imem_rdata_1    = '0;
    free_slots      = free_w'(`FE_MAX_FREE);
    free_prev       = free_w'(`FE_MAX_FREE);
    wb_valid        = 1'b0;
    wb_rd           = '0;
    next_fetch_addr = `FE_RESET_PC;
    prog_len        = 0;
    issued          = 0;
    cycle_count     = 0;

    reset_and_fetch_order();
    independent_pairs();
    pair_dependence();
    scoreboard_wait();
    back_pressure();

    repeat (5) @(posedge clk);
    $display("Simulation PASSED");
    $finish;
  end

endmodule

/* tb/fe_assert.sv */
// Issue-rule checks on the front end ports; free_slots is assumed to change only between edges.
`include "fe_defs.svh"

module fe_assert (
  input logic                                 clk,
  input logic                                 reset,
  input logic                                 imem_req,
  input logic                                 imem_valid,
  input logic [$clog2(`FE_MAX_FREE + 1)-1:0] free_slots,
  input logic                                 issue_valid_0,
  input logic                                 issue_valid_1
);
  timeunit 1ns;
  timeprecision 100ps;

  logic req_open;                             // a fetch is in flight.

  always_ff @(posedge clk) begin
    if (reset) begin
      req_open <= 1'b0;
    end else if (imem_req) begin
      req_open <= 1'b1;
    end else if (imem_valid) begin
      req_open <= 1'b0;
    end
  end

  no_room_no_issue: assert property (@(posedge clk) disable iff (reset)
    (free_slots == '0) |=> !(issue_valid_0 || issue_valid_1))
    else $error("issue in the cycle after free_slots was zero");

  one_room_one_issue: assert property (@(posedge clk) disable iff (reset)
    (free_slots == 'd1) |=> !(issue_valid_0 && issue_valid_1))
    else $error("two issues in the cycle after free_slots was one");

  single_request: assert property (@(posedge clk) disable iff (reset)
    req_open |-> !imem_req)
    else $error("imem_req while a fetch was still outstanding");

endmodule

bind instr_frontend fe_assert assert_i (
  .clk           (clk),
  .reset         (reset),
  .imem_req      (imem_req),
  .imem_valid    (imem_valid),
  .free_slots    (free_slots),
  .issue_valid_0 (issue_valid_0),
  .issue_valid_1 (issue_valid_1)
);

/* tb/fe_clock_gen.sv */
// Free-running 20 ns clock; reset is released 2 ns after the eighth rising edge.
module fe_clock_gen (
  output logic clk,
  output logic reset
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    reset = 1'b1;
    repeat (8) @(posedge clk);
    #2;
    reset = 1'b0;                             // off the edge, like all inputs.
  end

endmodule

/* hdl/instr_frontend.sv */
// Dual-issue front end with no redirect or flush. Fetch runs sequentially from FE_RESET_PC after reset.
`include "fe_defs.svh"

module instr_frontend import fe_pkg::*; (
  input  logic                                 clk,
  input  logic                                 reset,
  output logic                                 imem_req,
  output logic [`FE_XLEN-1:0]                  imem_addr,
  input  logic                                 imem_valid,
  input  logic [31:0]                          imem_rdata_0,
  input  logic [31:0]                          imem_rdata_1,
  input  logic [$clog2(`FE_MAX_FREE + 1)-1:0] free_slots,
  input  logic                                 wb_valid,
  input  logic [$clog2(`FE_NREGS)-1:0]         wb_rd,
  output logic                                 issue_valid_0,
  output logic [`FE_XLEN-1:0]                  issue_pc_0,
  output fe_op_e                               issue_op_0,
  output logic [$clog2(`FE_NREGS)-1:0]         issue_rd_0, issue_rs1_0, issue_rs2_0,
  output logic [`FE_XLEN-1:0]                  issue_imm_0,
  output logic                                 issue_valid_1,
  output logic [`FE_XLEN-1:0]                  issue_pc_1,
  output fe_op_e                               issue_op_1,
  output logic [$clog2(`FE_NREGS)-1:0]         issue_rd_1, issue_rs1_1, issue_rs2_1,
  output logic [`FE_XLEN-1:0]                  issue_imm_1
);

  logic                         stall;
  logic                         pair_valid;
  logic [`FE_XLEN-1:0]          pair_pc;
  logic [31:0]                  word_0, word_1;
  logic                         dec_valid_0, dec_valid_1;
  logic [`FE_XLEN-1:0]          dec_pc_0, dec_pc_1;
  fe_op_e                       dec_op_0, dec_op_1;
  logic [$clog2(`FE_NREGS)-1:0] dec_rd_0, dec_rs1_0, dec_rs2_0;
  logic [$clog2(`FE_NREGS)-1:0] dec_rd_1, dec_rs1_1, dec_rs2_1;
  logic                         dec_uses_rs1_0, dec_uses_rs2_0, dec_writes_rd_0;
  logic                         dec_uses_rs1_1, dec_uses_rs2_1, dec_writes_rd_1;
  logic [`FE_XLEN-1:0]          dec_imm_0, dec_imm_1;

  instr_loader loader (
    .clk          (clk),
    .reset        (reset),
    .stall        (stall),
    .imem_req     (imem_req),
    .imem_addr    (imem_addr),
    .imem_valid   (imem_valid),
    .imem_rdata_0 (imem_rdata_0),
    .imem_rdata_1 (imem_rdata_1),
    .pair_valid   (pair_valid),
    .pair_pc      (pair_pc),
    .word_0       (word_0),
    .word_1       (word_1)
  );

  instr_decoder decoder_0 (
    .clk           (clk),
    .reset         (reset),
    .stall         (stall),
    .in_valid      (pair_valid),
    .in_pc         (pair_pc),
    .in_word       (word_0),
    .dec_valid     (dec_valid_0),
    .dec_pc        (dec_pc_0),
    .dec_op        (dec_op_0),
    .dec_rd        (dec_rd_0),
    .dec_rs1       (dec_rs1_0),
    .dec_rs2       (dec_rs2_0),
    .dec_uses_rs1  (dec_uses_rs1_0),
    .dec_uses_rs2  (dec_uses_rs2_0),
    .dec_writes_rd (dec_writes_rd_0),
    .dec_imm       (dec_imm_0)
  );

  // second word of the pair sits 4 bytes above the pair pc.
  instr_decoder decoder_1 (
    .clk           (clk),
    .reset         (reset),
    .stall         (stall),
    .in_valid      (pair_valid),
    .in_pc         (pair_pc + 'd4),
    .in_word       (word_1),
    .dec_valid     (dec_valid_1),
    .dec_pc        (dec_pc_1),
    .dec_op        (dec_op_1),
    .dec_rd        (dec_rd_1),
    .dec_rs1       (dec_rs1_1),
    .dec_rs2       (dec_rs2_1),
    .dec_uses_rs1  (dec_uses_rs1_1),
    .dec_uses_rs2  (dec_uses_rs2_1),
    .dec_writes_rd (dec_writes_rd_1),
    .dec_imm       (dec_imm_1)
  );

  pair_issuer issuer (
    .clk             (clk),
    .reset           (reset),
    .dec_valid_0     (dec_valid_0),
    .dec_pc_0        (dec_pc_0),
    .dec_op_0        (dec_op_0),
    .dec_rd_0        (dec_rd_0),
    .dec_rs1_0       (dec_rs1_0),
    .dec_rs2_0       (dec_rs2_0),
    .dec_uses_rs1_0  (dec_uses_rs1_0),
    .dec_uses_rs2_0  (dec_uses_rs2_0),
    .dec_writes_rd_0 (dec_writes_rd_0),
    .dec_imm_0       (dec_imm_0),
    .dec_valid_1     (dec_valid_1),
    .dec_pc_1        (dec_pc_1),
    .dec_op_1        (dec_op_1),
    .dec_rd_1        (dec_rd_1),
    .dec_rs1_1       (dec_rs1_1),
    .dec_rs2_1       (dec_rs2_1),
    .dec_uses_rs1_1  (dec_uses_rs1_1),
    .dec_uses_rs2_1  (dec_uses_rs2_1),
    .dec_writes_rd_1 (dec_writes_rd_1),
    .dec_imm_1       (dec_imm_1),
    .free_slots      (free_slots),
    .wb_valid        (wb_valid),
    .wb_rd           (wb_rd),
    .stall           (stall),
    .issue_valid_0   (issue_valid_0),
    .issue_pc_0      (issue_pc_0),
    .issue_op_0      (issue_op_0),
    .issue_rd_0      (issue_rd_0),
    .issue_rs1_0     (issue_rs1_0),
    .issue_rs2_0     (issue_rs2_0),
    .issue_imm_0     (issue_imm_0),
    .issue_valid_1   (issue_valid_1),
    .issue_pc_1      (issue_pc_1),
    .issue_op_1      (issue_op_1),
    .issue_rd_1      (issue_rd_1),
    .issue_rs1_1     (issue_rs1_1),
    .issue_rs2_1     (issue_rs2_1),
    .issue_imm_1     (issue_imm_1)
  );

endmodule

/* hdl/pair_issuer.sv */
// In-order pair issue. A second writer of a busy register is not tracked, and any writeback to it clears the busy bit.
`include "fe_defs.svh"

module pair_issuer import fe_pkg::*; (
  input  logic                                 clk,
  input  logic                                 reset,
  input  logic                                 dec_valid_0,
  input  logic [`FE_XLEN-1:0]                  dec_pc_0,
  input  fe_op_e                               dec_op_0,
  input  logic [$clog2(`FE_NREGS)-1:0]         dec_rd_0, dec_rs1_0, dec_rs2_0,
  input  logic                                 dec_uses_rs1_0, dec_uses_rs2_0, dec_writes_rd_0,
  input  logic [`FE_XLEN-1:0]                  dec_imm_0,
  input  logic                                 dec_valid_1,
  input  logic [`FE_XLEN-1:0]                  dec_pc_1,
  input  fe_op_e                               dec_op_1,
  input  logic [$clog2(`FE_NREGS)-1:0]         dec_rd_1, dec_rs1_1, dec_rs2_1,
  input  logic                                 dec_uses_rs1_1, dec_uses_rs2_1, dec_writes_rd_1,
  input  logic [`FE_XLEN-1:0]                  dec_imm_1,
  input  logic [$clog2(`FE_MAX_FREE + 1)-1:0] free_slots,
  input  logic                                 wb_valid,
  input  logic [$clog2(`FE_NREGS)-1:0]         wb_rd,
  output logic                                 stall,
  output logic                                 issue_valid_0,
  output logic [`FE_XLEN-1:0]                  issue_pc_0,
  output fe_op_e                               issue_op_0,
  output logic [$clog2(`FE_NREGS)-1:0]         issue_rd_0, issue_rs1_0, issue_rs2_0,
  output logic [`FE_XLEN-1:0]                  issue_imm_0,
  output logic                                 issue_valid_1,
  output logic [`FE_XLEN-1:0]                  issue_pc_1,
  output fe_op_e                               issue_op_1,
  output logic [$clog2(`FE_NREGS)-1:0]         issue_rd_1, issue_rs1_1, issue_rs2_1,
  output logic [`FE_XLEN-1:0]                  issue_imm_1
);

  localparam int reg_w  = $clog2(`FE_NREGS);
  localparam int free_w = $clog2(`FE_MAX_FREE + 1);

  logic [`FE_NREGS-1:0] busy;
  logic [`FE_NREGS-1:0] busy_next;
  logic                 slot0_done;     // slot 0 left, slot 1 still waiting.
  logic                 src_busy_0;
  logic                 src_busy_1;
  logic                 pair_dep;
  logic                 go_0;
  logic                 go_1;
  logic                 clear_0;
  logic                 clear_1;

  function automatic logic srcs_busy(
    input logic [`FE_NREGS-1:0] sb,
    input logic                 use_a,
    input logic [reg_w-1:0]     reg_a,
    input logic                 use_b,
    input logic [reg_w-1:0]     reg_b
  );
    return (use_a & sb[reg_a]) | (use_b & sb[reg_b]);
  endfunction

  // ##########################################################################
  // hazard and capacity checks

  assign src_busy_0 = srcs_busy(busy, dec_uses_rs1_0, dec_rs1_0, dec_uses_rs2_0, dec_rs2_0);
  assign src_busy_1 = srcs_busy(busy, dec_uses_rs1_1, dec_rs1_1, dec_uses_rs2_1, dec_rs2_1);

  // slot 1 reads what slot 0 writes.
  assign pair_dep = dec_writes_rd_0 &
                    ((dec_uses_rs1_1 & (dec_rs1_1 == dec_rd_0)) |
                     (dec_uses_rs2_1 & (dec_rs2_1 == dec_rd_0)));

  assign go_0    = dec_valid_0 & ~slot0_done & ~src_busy_0 & (free_slots != '0);
  assign clear_0 = ~dec_valid_0 | slot0_done | go_0;
  assign go_1    = dec_valid_1 & clear_0 & ~src_busy_1 & ~(go_0 & pair_dep) &
                   (free_slots > free_w'(go_0));  // two entries when both go.
  assign clear_1 = ~dec_valid_1 | go_1;
  assign stall   = ~(clear_0 & clear_1);

  // ##########################################################################
  // scoreboard

  always_comb begin
    busy_next = busy;
    if (wb_valid) begin
      busy_next[wb_rd] = 1'b0;
    end
    if (go_0 && dec_writes_rd_0) begin
      busy_next[dec_rd_0] = 1'b1;
    end
    if (go_1 && dec_writes_rd_1) begin
      busy_next[dec_rd_1] = 1'b1;
    end
    busy_next[0] = 1'b0;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      busy       <= '0;
      slot0_done <= 1'b0;
    end else begin
      busy <= busy_next;
      if (!stall) begin
        slot0_done <= 1'b0;                 // next pair starts fresh.
      end else if (go_0) begin
        slot0_done <= 1'b1;
      end
    end
  end

  // ##########################################################################
  // issue registers

  always_ff @(posedge clk) begin
    if (reset) begin
      issue_valid_0 <= 1'b0;
      issue_valid_1 <= 1'b0;
    end else begin
      issue_valid_0 <= go_0;
      issue_valid_1 <= go_1;
    end
  end

  always_ff @(posedge clk) begin
    if (go_0) begin
      issue_pc_0  <= dec_pc_0;
      issue_op_0  <= dec_op_0;
      issue_rd_0  <= dec_rd_0;
      issue_rs1_0 <= dec_rs1_0;
      issue_rs2_0 <= dec_rs2_0;
      issue_imm_0 <= dec_imm_0;
    end
    if (go_1) begin
      issue_pc_1  <= dec_pc_1;
      issue_op_1  <= dec_op_1;
      issue_rd_1  <= dec_rd_1;
      issue_rs1_1 <= dec_rs1_1;
      issue_rs2_1 <= dec_rs2_1;
      issue_imm_1 <= dec_imm_1;
    end
  end

endmodule

/* hdl/instr_decoder.sv */
// Decodes by opcode alone and does not check funct3 or funct7, so a malformed word in a known class passes as that class.
`include "fe_defs.svh"

module instr_decoder import fe_pkg::*; (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         stall,
  input  logic                         in_valid,
  input  logic [`FE_XLEN-1:0]          in_pc,
  input  logic [31:0]                  in_word,
  output logic                         dec_valid,
  output logic [`FE_XLEN-1:0]          dec_pc,
  output fe_op_e                       dec_op,
  output logic [$clog2(`FE_NREGS)-1:0] dec_rd,
  output logic [$clog2(`FE_NREGS)-1:0] dec_rs1,
  output logic [$clog2(`FE_NREGS)-1:0] dec_rs2,
  output logic                         dec_uses_rs1,
  output logic                         dec_uses_rs2,
  output logic                         dec_writes_rd,
  output logic [`FE_XLEN-1:0]          dec_imm
);

  localparam int reg_w = $clog2(`FE_NREGS);

  localparam logic [6:0] opc_op     = 7'b0110011;
  localparam logic [6:0] opc_op_imm = 7'b0010011;
  localparam logic [6:0] opc_load   = 7'b0000011;
  localparam logic [6:0] opc_store  = 7'b0100011;
  localparam logic [6:0] opc_lui    = 7'b0110111;

  fe_instr_u           word;
  fe_op_e              op_d;
  logic                uses_rs1_d;
  logic                uses_rs2_d;
  logic                writes_rd_d;
  logic [reg_w-1:0]    rd_d;
  logic [reg_w-1:0]    rs1_d;
  logic [reg_w-1:0]    rs2_d;
  logic [`FE_XLEN-1:0] imm_d;

  function automatic logic [`FE_XLEN-1:0] sext12(input logic [11:0] v);
    return {{(`FE_XLEN - 12){v[11]}}, v};
  endfunction

  assign word = in_word;

  // ##########################################################################
  // class and operand usage

  always_comb begin
    op_d        = op_illegal;
    uses_rs1_d  = 1'b0;
    uses_rs2_d  = 1'b0;
    writes_rd_d = 1'b0;
    imm_d       = '0;
    case (word.r.opcode)
      opc_op: begin
        op_d        = op_alu;
        uses_rs1_d  = 1'b1;
        uses_rs2_d  = 1'b1;
        writes_rd_d = 1'b1;
      end
      opc_op_imm: begin
        op_d        = op_alu_imm;
        uses_rs1_d  = 1'b1;
        writes_rd_d = 1'b1;
        imm_d       = sext12(word.i.imm12);
      end
      opc_load: begin
        op_d        = op_load;
        uses_rs1_d  = 1'b1;
        writes_rd_d = 1'b1;
        imm_d       = sext12(word.i.imm12);
      end
      opc_store: begin
        op_d       = op_store;
        uses_rs1_d = 1'b1;
        uses_rs2_d = 1'b1;
        imm_d      = sext12({word.r.funct7, word.r.rd});  // split immediate.
      end
      opc_lui: begin
        op_d        = op_lui;
        writes_rd_d = 1'b1;
        imm_d       = {word.i.imm12, word.i.rs1, word.i.funct3, 12'b0};
      end
      default: begin
        op_d = op_illegal;
      end
    endcase
    if (word.r.rd == '0) begin
      writes_rd_d = 1'b0;                     // x0 is never a destination.
    end
  end

  // unused register fields read as zero.
  assign rd_d  = writes_rd_d ? word.r.rd : '0;
  assign rs1_d = uses_rs1_d ? word.r.rs1 : '0;
  assign rs2_d = uses_rs2_d ? word.r.rs2 : '0;

  // ##########################################################################
  // output registers

  always_ff @(posedge clk) begin
    if (reset) begin
      dec_valid <= 1'b0;
    end else if (!stall) begin
      dec_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      dec_pc        <= in_pc;
      dec_op        <= op_d;
      dec_rd        <= rd_d;
      dec_rs1       <= rs1_d;
      dec_rs2       <= rs2_d;
      dec_uses_rs1  <= uses_rs1_d;
      dec_uses_rs2  <= uses_rs2_d;
      dec_writes_rd <= writes_rd_d;
      dec_imm       <= imm_d;
    end
  end

endmodule

/* hdl/instr_loader.sv */
// Sequential fetch with one request in flight. The memory must answer at least one cycle after imem_req.
`include "fe_defs.svh"

module instr_loader (
  input  logic                clk,
  input  logic                reset,
  input  logic                stall,
  output logic                imem_req,
  output logic [`FE_XLEN-1:0] imem_addr,
  input  logic                imem_valid,
  input  logic [31:0]         imem_rdata_0,
  input  logic [31:0]         imem_rdata_1,
  output logic                pair_valid,
  output logic [`FE_XLEN-1:0] pair_pc,
  output logic [31:0]         word_0,
  output logic [31:0]         word_1
);

  logic [`FE_XLEN-1:0] fetch_pc;
  logic                req_pending;
  logic                buf_full;
  logic                buf_taken;
  logic                buf_free;

  assign buf_taken  = buf_full & ~stall;      // decoders load the pair.
  assign buf_free   = ~buf_full | buf_taken;
  assign imem_addr  = fetch_pc;
  assign pair_valid = buf_full;

  // ##########################################################################
  // request control

  always_ff @(posedge clk) begin
    if (reset) begin
      imem_req    <= 1'b0;
      req_pending <= 1'b0;
      fetch_pc    <= `FE_RESET_PC;
    end else begin
      // ask again as soon as the buffer has room for the answer.
      imem_req <= ~req_pending & ~imem_req & buf_free;
      if (imem_req) begin
        req_pending <= 1'b1;
      end else if (imem_valid) begin
        req_pending <= 1'b0;
      end
      if (imem_valid) begin
        fetch_pc <= fetch_pc + 'd8;           // two words per pair.
      end
    end
  end

  // ##########################################################################
  // pair buffer

  always_ff @(posedge clk) begin
    if (reset) begin
      buf_full <= 1'b0;
    end else if (imem_valid) begin
      buf_full <= 1'b1;
    end else if (buf_taken) begin
      buf_full <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (imem_valid) begin
      pair_pc <= fetch_pc;
      word_0  <= imem_rdata_0;
      word_1  <= imem_rdata_1;
    end
  end

endmodule

/* hdl/fe_pkg.sv */
// Shared types for the decoders and the issuer. Both instruction views describe one 32-bit RV32I word.
package fe_pkg;

  // register-register layout, also used for the split store immediate.
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } fe_r_t;

  // immediate layout.
  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } fe_i_t;

  typedef union packed {
    fe_r_t r;
    fe_i_t i;
  } fe_instr_u;

  typedef enum logic [2:0] {
    op_alu     = 3'd0,
    op_alu_imm = 3'd1,
    op_load    = 3'd2,
    op_store   = 3'd3,
    op_lui     = 3'd4,
    op_illegal = 3'd7
  } fe_op_e;

endpackage

/* include/fe_defs.svh */
// Build constants for the front end. FE_XLEN must stay 32 because the instruction views are fixed RV32I words.
`ifndef FE_DEFS_SVH
`define FE_DEFS_SVH

// ##########################################################################
// datapath

`define FE_XLEN 32                  // address and immediate width.
`define FE_RESET_PC 32'h0000_1000   // first fetch address, 8-byte aligned.

// ##########################################################################
// register file and issue capacity

`define FE_NREGS 32                 // scoreboard width, 5-bit register fields.
`define FE_MAX_FREE 3               // largest free_slots value, 2 bits.

`endif
